// File: design/chroma_carrier_gen.sv
`timescale 1ns/100ps

module chroma_carrier_gen (
    input  logic                       clk_col16x,
    input  logic                       rst,
    input  comp_video_pkg::sync_info_t decoded,
    output comp_video_pkg::level_t     chroma
);
    import comp_video_pkg::*;

    // 16 samples per carrier period
    logic [3:0]  phase_cnt;
    logic        burst_pending;
    logic        in_burst;
    burst_cnt_t  burst_cnt;
    logic        odd_line;

    logic        pal;
    logic        odd_now;
    logic        pending_now;
    logic        burst_now;
    logic        burst_done;
    amp_t        amp_sel;
    phase_t      offset;
    phase_t      wave_addr;
    // {amplitude, phase} into the sine table
    logic [10:0] rom_addr;
    amp_t        amp_d;
    logic [8:0]  rom_data;

    // quarter wave table with midpoint samples, 64 steps per period,
    // scaled by the amplitude gain around a centre of 256
    function automatic logic [8:0] sine_lookup(input logic [10:0] addr);
        logic [1:0]  quad;
        logic [3:0]  idx;
        logic [7:0]  mag;
        logic [11:0] scaled;
        quad = addr[7:6];
        idx = quad[0] ? ~addr[5:2] : addr[5:2];
        case (idx)
            4'd0:  mag = 8'd13;
            4'd1:  mag = 8'd37;
            4'd2:  mag = 8'd62;
            4'd3:  mag = 8'd86;
            4'd4:  mag = 8'd109;
            4'd5:  mag = 8'd131;
            4'd6:  mag = 8'd152;
            4'd7:  mag = 8'd171;
            4'd8:  mag = 8'd189;
            4'd9:  mag = 8'd205;
            4'd10: mag = 8'd219;
            4'd11: mag = 8'd231;
            4'd12: mag = 8'd240;
            4'd13: mag = 8'd247;
            4'd14: mag = 8'd252;
            default: mag = 8'd255;
        endcase
        scaled = mag * AMP_GAIN[addr[10:8]];
        // lower half period swings below the centre
        return quad[1] ? 9'd256 - {1'b0, scaled[11:4]} : 9'd256 + {1'b0, scaled[11:4]};
    endfunction

    always_comb
    begin
        pal = decoded.chip[0];
        // toggle and rearm take effect on the first sample of the new line
        odd_now = odd_line ^ decoded.new_line;
        pending_now = burst_pending || decoded.new_line;
        burst_now = in_burst || (pending_now && decoded.burst_start_hit);
        // last of the BURST_SAMPLES plus one burst cycles
        burst_done = burst_now && (burst_cnt == BURST_SAMPLES);

        if (decoded.native_active)
            amp_sel = PALETTE_AMP[decoded.color];
        else if (burst_now)
            amp_sel = BURST_AMP;
        else
            amp_sel = AMP_NONE;

        // PAL reflects the colour phase on odd lines, burst swings 135 / -135
        if (decoded.native_active)
            offset = (pal && odd_now) ? 8'd0 - PALETTE_PHASE[decoded.color] :
                                        PALETTE_PHASE[decoded.color];
        else if (!pal)
            offset = NTSC_BURST_PHASE;
        else
            offset = odd_now ? PAL_BURST_PHASE_ODD : PAL_BURST_PHASE_EVEN;

        wave_addr = {phase_cnt, 4'b0000} + offset;
        rom_data = sine_lookup(rom_addr);
    end

    always_ff @(posedge clk_col16x)
    begin
        if (rst)
        begin
            phase_cnt <= '0;
            burst_pending <= 1'b0;
            in_burst <= 1'b0;
            burst_cnt <= '0;
            odd_line <= 1'b0;
            amp_d <= AMP_NONE;
            chroma <= CHROMA_ZERO;
        end
        else
        begin
            phase_cnt <= phase_cnt + 4'd1;
            odd_line <= odd_now;
            if (burst_done)
            begin
                in_burst <= 1'b0;
                burst_pending <= 1'b0;
                burst_cnt <= '0;
            end
            else
            begin
                in_burst <= burst_now;
                burst_pending <= pending_now;
                if (burst_now)
                    burst_cnt <= burst_cnt + 8'd1;
            end
            // amplitude follows the address so the zero decision lines up
            amp_d <= amp_sel;
            chroma <= (amp_d == AMP_NONE) ? CHROMA_ZERO : rom_data[8:3];
        end
    end

    always_ff @(posedge clk_col16x)
    begin
        rom_addr <= {amp_sel, wave_addr};
    end

    a_burst_cnt_range: assert property (
        @(posedge clk_col16x) disable iff (rst)
        burst_cnt <= BURST_SAMPLES
    );

endmodule

// File: design/comp_sync.sv
`timescale 1ns/100ps

// composite sync, luma and chroma back end
// decode at N+1, luma and csync at N+2, chroma at N+3
module comp_sync (
    input  logic                       clk_col16x,
    input  logic                       rst,
    input  comp_video_pkg::chip_t      chip,
    input  comp_video_pkg::raster_x_t  raster_x,
    input  comp_video_pkg::raster_y_t  raster_y,
    input  comp_video_pkg::color_idx_t pixel_color,
    output logic                       csync,
    output comp_video_pkg::level_t     luma,
    output comp_video_pkg::level_t     chroma,
    output logic                       native_active
);
    import comp_video_pkg::*;

    // one registered decode result feeds both output stages
    sync_info_t decoded;

    raster_sync_decode u_decode (
        .clk_col16x (clk_col16x),
        .rst        (rst),
        .raster_x   (raster_x),
        .raster_y   (raster_y),
        .color      (pixel_color),
        .chip       (chip),
        .decoded    (decoded)
    );

    chroma_carrier_gen u_carrier (
        .clk_col16x (clk_col16x),
        .rst        (rst),
        .decoded    (decoded),
        .chroma     (chroma)
    );

    video_level_out u_level (
        .clk_col16x    (clk_col16x),
        .rst           (rst),
        .decoded       (decoded),
        .luma          (luma),
        .csync         (csync),
        .native_active (native_active)
    );

endmodule

// File: design/comp_video_pkg.sv
`include "vic_chip_codes.svh"

package comp_video_pkg;

    typedef logic [1:0] chip_t;
    typedef logic [9:0] raster_x_t;
    typedef logic [8:0] raster_y_t;
    typedef logic [3:0] color_idx_t;
    // luma and chroma output levels
    typedef logic [5:0] level_t;
    // chroma amplitude select, 7 means no carrier
    typedef logic [2:0] amp_t;
    // 256 steps per carrier period
    typedef logic [7:0] phase_t;
    typedef logic [3:0] vsync_line_t;
    typedef logic [7:0] burst_cnt_t;
    typedef logic [3:0] gain_t;

    localparam level_t LEVEL_BLANK = 6'd18;
    localparam level_t LEVEL_SYNC = 6'd0;
    localparam level_t CHROMA_ZERO = 6'd32;
    localparam amp_t AMP_NONE = 3'd7;
    localparam amp_t BURST_AMP = 3'd2;
    // 9 carrier periods of 16 samples each
    localparam burst_cnt_t BURST_SAMPLES = 8'd144;
    localparam phase_t NTSC_BURST_PHASE = 8'd128;
    localparam phase_t PAL_BURST_PHASE_ODD = 8'd160;
    localparam phase_t PAL_BURST_PHASE_EVEN = 8'd96;

    // vertical sync block, lines 3 to 5 carry serration, the rest equalization
    localparam raster_y_t VSYNC_LINES = 9'd9;
    localparam vsync_line_t SERR_FIRST_LINE = 4'd3;
    localparam vsync_line_t SERR_LAST_LINE = 4'd5;

    typedef struct packed {
        raster_x_t hsync_start;
        raster_x_t hsync_end;
        raster_x_t visible_start;
        raster_x_t burst_start;
        raster_y_t vblank_start;
        raster_y_t vblank_end;
    } timing_t;

    // roughly 0.122 us per x step on NTSC, 0.127 us on PAL
    localparam timing_t TIMING_NTSC = '{10'd409, 10'd446, 10'd497, 10'd451, 9'd14, 9'd22};
    localparam timing_t TIMING_PAL = '{10'd408, 10'd444, 10'd492, 10'd449, 9'd301, 9'd309};

    // eq pulses sit on the two half line points, serration is sync level
    // except for a gap of about 4.7 us ahead of each half line point
    typedef struct packed {
        raster_x_t eq_a_start;
        raster_x_t eq_a_end;
        raster_x_t eq_b_start;
        raster_x_t eq_b_end;
        raster_x_t gap_a_start;
        raster_x_t gap_a_end;
        raster_x_t gap_b_start;
        raster_x_t gap_b_end;
    } pulse_t;

    localparam pulse_t PULSE_NTSC = '{10'd149, 10'd168, 10'd409, 10'd428,
                                      10'd111, 10'd149, 10'd371, 10'd409};
    localparam pulse_t PULSE_PAL = '{10'd156, 10'd174, 10'd408, 10'd426,
                                     10'd119, 10'd156, 10'd371, 10'd408};

    localparam level_t PALETTE_LUMA [16] = '{
        6'd18, 6'd56, 6'd29, 6'd45,
        6'd33, 6'd40, 6'd26, 6'd52,
        6'd33, 6'd26, 6'd40, 6'd29,
        6'd37, 6'd52, 6'd37, 6'd45
    };
    // greys carry no carrier
    localparam amp_t PALETTE_AMP [16] = '{
        3'd7, 3'd7, 3'd2, 3'd2,
        3'd1, 3'd1, 3'd0, 3'd1,
        3'd1, 3'd3, 3'd2, 3'd7,
        3'd7, 3'd1, 3'd0, 3'd7
    };
    localparam phase_t PALETTE_PHASE [16] = '{
        8'd0,   8'd0,   8'd80,  8'd208,
        8'd32,  8'd160, 8'd0,   8'd128,
        8'd96,  8'd112, 8'd80,  8'd0,
        8'd0,   8'd160, 8'd0,   8'd0
    };
    // peak scale per amplitude select, in sixteenths of full swing
    localparam gain_t AMP_GAIN [8] = '{4'd15, 4'd12, 4'd9, 4'd7, 4'd5, 4'd4, 4'd3, 4'd0};

    typedef struct packed {
        logic        native_active;
        logic        hsync;
        vsync_line_t vsync_line;
        logic        in_vsync;
        logic        eq;
        logic        se;
        logic        burst_start_hit;
        logic        new_line;
        color_idx_t  color;
        chip_t       chip;
    } sync_info_t;

    function automatic timing_t chip_timing(input chip_t chip);
        case (chip)
            `CHIP6567R8, `CHIP6567R56A:
                return TIMING_NTSC;
            default:
                return TIMING_PAL;
        endcase
    endfunction

    function automatic pulse_t chip_pulse(input chip_t chip);
        return chip[0] ? PULSE_PAL : PULSE_NTSC;
    endfunction

endpackage

// File: design/raster_sync_decode.sv
`timescale 1ns/100ps

module raster_sync_decode (
    input  logic                       clk_col16x,
    input  logic                       rst,
    input  comp_video_pkg::raster_x_t  raster_x,
    input  comp_video_pkg::raster_y_t  raster_y,
    input  comp_video_pkg::color_idx_t color,
    input  comp_video_pkg::chip_t      chip,
    output comp_video_pkg::sync_info_t decoded
);
    import comp_video_pkg::*;

    timing_t    timing;
    pulse_t     pulse;
    raster_y_t  prev_y;
    // line number relative to vblank start, wraps for lines above it
    raster_y_t  line_ofs;
    logic       in_vsync;
    logic       eq_pulse;
    logic       se_gap;
    sync_info_t next_info;

    always_comb
    begin
        timing = chip_timing(chip);
        pulse = chip_pulse(chip);

        line_ofs = raster_y - timing.vblank_start;
        in_vsync = line_ofs < VSYNC_LINES;

        // two narrow pulses per line, one on each half line point
        eq_pulse = (raster_x >= pulse.eq_a_start && raster_x < pulse.eq_a_end) ||
                   (raster_x >= pulse.eq_b_start && raster_x < pulse.eq_b_end);
        // broad pulses, the gaps are where the level returns to blank
        se_gap = (raster_x >= pulse.gap_a_start && raster_x < pulse.gap_a_end) ||
                 (raster_x >= pulse.gap_b_start && raster_x < pulse.gap_b_end);

        // visible span wraps around the end of the line
        next_info.native_active = (raster_x < timing.hsync_start ||
                                   raster_x >= timing.visible_start) &&
                                  (raster_y < timing.vblank_start ||
                                   raster_y > timing.vblank_end);
        next_info.hsync = raster_x >= timing.hsync_start && raster_x < timing.hsync_end;
        next_info.vsync_line = in_vsync ? line_ofs[3:0] : '0;
        next_info.in_vsync = in_vsync;
        // eq and se only mean something inside the vsync block
        next_info.eq = in_vsync && eq_pulse;
        next_info.se = in_vsync && !se_gap;
        next_info.burst_start_hit = raster_x >= timing.burst_start;
        // any change of line, also after a jump, rearms the burst
        next_info.new_line = raster_y != prev_y;
        next_info.color = color;
        next_info.chip = chip;
    end

    always_ff @(posedge clk_col16x)
    begin
        if (rst)
        begin
            decoded <= '0;
            prev_y <= '0;
        end
        else
        begin
            decoded <= next_info;
            prev_y <= raster_y;
        end
    end

    // registered pulses must trace back to a line inside the vblank range
    // of the chip that was selected one cycle earlier
    a_pulse_in_vsync: assert property (
        @(posedge clk_col16x) disable iff (rst)
        (decoded.eq || decoded.se) |->
            $past(raster_y >= timing.vblank_start && raster_y <= timing.vblank_end)
    );

endmodule

// File: design/video_level_out.sv
`timescale 1ns/100ps

module video_level_out (
    input  logic                       clk_col16x,
    input  logic                       rst,
    input  comp_video_pkg::sync_info_t decoded,
    output comp_video_pkg::level_t     luma,
    output logic                       csync,
    output logic                       native_active
);
    import comp_video_pkg::*;

    logic   serr_line;
    logic   sync_active;
    level_t luma_next;

    always_comb
    begin
        // middle three lines of the vsync block carry broad pulses
        serr_line = decoded.vsync_line >= SERR_FIRST_LINE &&
                    decoded.vsync_line <= SERR_LAST_LINE;

        if (decoded.in_vsync)
            sync_active = serr_line ? decoded.se : decoded.eq;
        else
            sync_active = decoded.hsync;

        // sync tip wins, then blanking, then the palette level
        if (sync_active)
            luma_next = LEVEL_SYNC;
        else if (!decoded.native_active)
            luma_next = LEVEL_BLANK;
        else
            luma_next = PALETTE_LUMA[decoded.color];
    end

    always_ff @(posedge clk_col16x)
    begin
        if (rst)
        begin
            luma <= '0;
            csync <= 1'b0;
            native_active <= 1'b0;
        end
        else
        begin
            luma <= luma_next;
            // csync is active low
            csync <= ~sync_active;
            native_active <= decoded.native_active;
        end
    end

    // on normal lines a low csync comes with the sync tip level
    // and always falls inside the horizontal blanking span
    a_sync_luma: assert property (
        @(posedge clk_col16x) disable iff (rst)
        (!csync && !$past(decoded.in_vsync)) |-> (luma == LEVEL_SYNC && !native_active)
    );

endmodule

// File: include/vic_chip_codes.svh
`ifndef VIC_CHIP_CODES_SVH
`define VIC_CHIP_CODES_SVH

// chip model codes as driven on the chip input
// bit 0 set marks a PAL part, the timing and burst logic key off it

// NTSC part, 65 cycles per line
`define CHIP6567R8   2'd0

// PAL part, 63 cycles per line
`define CHIP6569     2'd1

// older NTSC part, 64 cycles per line
`define CHIP6567R56A 2'd2

// no real chip behind this code, runs with PAL timing
`define CHIPUNUSED   2'd3

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the composite video testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module comp_sync_tb -o comp_sync_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/comp_sync_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
    exit 0
else
    exit 1
fi

// File: sim.f
+incdir+include
design/comp_video_pkg.sv
design/raster_sync_decode.sv
design/chroma_carrier_gen.sv
design/video_level_out.sv
design/comp_sync.sv
sim/comp_sync_tb.sv

// File: sim/comp_sync_tb.sv
`timescale 1ns/100ps
`include "vic_chip_codes.svh"

module comp_sync_tb;
    import comp_video_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 16;
    // lines walked per chip, vblank block plus three lines either side
    localparam int LINES_PER_CHIP = 15;
    localparam int MAX_LINE_LEN = 520;
    localparam int NUM_CHIPS = 4;
    localparam int WATCHDOG_NS = (NUM_CHIPS * LINES_PER_CHIP * MAX_LINE_LEN + 2000) * CLK_PERIOD;
    localparam logic [31:0] RAND_SEED = 32'hb3a332ce;
    localparam chip_t CHIP_LIST [NUM_CHIPS] = '{`CHIP6567R8, `CHIP6569, `CHIP6567R56A,
                                                `CHIPUNUSED};

    // expected outputs of one input cycle
    typedef struct packed {
        logic   active;
        logic   csync;
        level_t luma;
        amp_t   amp;
    } expect_t;

    logic       clk_col16x;
    logic       rst;
    chip_t      chip;
    raster_x_t  raster_x;
    raster_y_t  raster_y;
    color_idx_t pixel_color;
    logic       csync;
    level_t     luma;
    level_t     chroma;
    logic       native_active;

    // reference model
    timing_t    t_cur;
    pulse_t     p_cur;
    raster_y_t  vline;
    logic       in_block;
    logic       eq_hit;
    logic       se_hit;
    logic       sync_now;
    logic       pend_now;
    logic       burst_now;
    expect_t    exp_now;
    expect_t    exp_d1;
    expect_t    exp_d2;
    expect_t    exp_d3;
    logic [2:0] valid_d;
    raster_y_t  prev_y;
    logic       pending;
    logic       in_burst;
    burst_cnt_t burst_cnt;

    int         rst_edges = 0;
    int         span_len = 0;
    logic       span_seen = 1'b0;
    int         bursts_seen = 0;
    int         err_reset = 0;
    int         err_active = 0;
    int         err_csync = 0;
    int         err_luma = 0;
    int         err_chroma = 0;

    comp_sync comp_sync_inst (
        .clk_col16x    (clk_col16x),
        .rst           (rst),
        .chip          (chip),
        .raster_x      (raster_x),
        .raster_y      (raster_y),
        .pixel_color   (pixel_color),
        .csync         (csync),
        .luma          (luma),
        .chroma        (chroma),
        .native_active (native_active)
    );

    initial clk_col16x = 1'b0;
    always #(CLK_PERIOD / 2) clk_col16x = ~clk_col16x;

    // bit 0 of the chip code marks the PAL parts
    function automatic timing_t select_timing(input chip_t c);
        return c[0] ? TIMING_PAL : TIMING_NTSC;
    endfunction

    function automatic pulse_t select_pulse(input chip_t c);
        return c[0] ? PULSE_PAL : PULSE_NTSC;
    endfunction

    // 8 raster x steps per cycle, 65, 64 or 63 cycles per line
    function automatic int line_length(input chip_t c);
        case (c)
            `CHIP6567R8:   return 520;
            `CHIP6567R56A: return 512;
            default:       return 504;
        endcase
    endfunction

    always_comb
    begin
        t_cur = select_timing(chip);
        p_cur = select_pulse(chip);
        vline = raster_y - t_cur.vblank_start;
        in_block = vline < 9'd9;
        eq_hit = (raster_x >= p_cur.eq_a_start && raster_x < p_cur.eq_a_end) ||
                 (raster_x >= p_cur.eq_b_start && raster_x < p_cur.eq_b_end);
        se_hit = !((raster_x >= p_cur.gap_a_start && raster_x < p_cur.gap_a_end) ||
                   (raster_x >= p_cur.gap_b_start && raster_x < p_cur.gap_b_end));
        // serration on block lines 3 to 5, equalization on the others
        if (in_block)
            sync_now = (vline >= 9'd3 && vline <= 9'd5) ? se_hit : eq_hit;
        else
            sync_now = raster_x >= t_cur.hsync_start && raster_x < t_cur.hsync_end;

        exp_now.active = (raster_x < t_cur.hsync_start || raster_x >= t_cur.visible_start) &&
                         (raster_y < t_cur.vblank_start || raster_y > t_cur.vblank_end);
        exp_now.csync = !sync_now;
        if (sync_now)
            exp_now.luma = LEVEL_SYNC;
        else if (!exp_now.active)
            exp_now.luma = LEVEL_BLANK;
        else
            exp_now.luma = PALETTE_LUMA[pixel_color];

        // a change of line arms the burst
        pend_now = pending || (raster_y != prev_y);
        burst_now = in_burst || (pend_now && raster_x >= t_cur.burst_start);
        if (exp_now.active)
            exp_now.amp = PALETTE_AMP[pixel_color];
        else if (burst_now)
            exp_now.amp = BURST_AMP;
        else
            exp_now.amp = AMP_NONE;
    end

    always @(posedge clk_col16x)
    begin
        prev_y <= raster_y;
        exp_d1 <= exp_now;
        exp_d2 <= exp_d1;
        exp_d3 <= exp_d2;
        if (rst)
        begin
            rst_edges <= rst_edges + 1;
            valid_d <= '0;
            pending <= 1'b0;
            in_burst <= 1'b0;
            burst_cnt <= '0;
        end
        else
        begin
            valid_d <= {valid_d[1:0], 1'b1};
            if (burst_now && !in_burst)
                bursts_seen <= bursts_seen + 1;
            // burst runs BURST_SAMPLES plus one cycles
            if (burst_now && burst_cnt == BURST_SAMPLES)
            begin
                in_burst <= 1'b0;
                pending <= 1'b0;
                burst_cnt <= '0;
            end
            else
            begin
                in_burst <= burst_now;
                pending <= pend_now;
                if (burst_now)
                    burst_cnt <= burst_cnt + 8'd1;
            end
        end
        // run of carrier samples at the chroma output
        if (valid_d[2] && exp_d3.amp != AMP_NONE)
        begin
            span_len <= span_len + 1;
            if (chroma != CHROMA_ZERO)
                span_seen <= 1'b1;
        end
        else
        begin
            span_len <= 0;
            span_seen <= 1'b0;
        end
    end

    a_reset_values: assert property (@(posedge clk_col16x)
        (rst && rst_edges > 0) |->
            (csync == 1'b0 && luma == '0 && native_active == 1'b0 && chroma == CHROMA_ZERO))
    else
    begin
        err_reset++;
        $display("[FAIL] reset csync=%h luma=%h chroma=%h native_active=%h",
                 $sampled(csync), $sampled(luma), $sampled(chroma), $sampled(native_active));
    end

    a_native_active: assert property (@(posedge clk_col16x) disable iff (rst)
        valid_d[1] |-> native_active == exp_d2.active)
    else
    begin
        err_active++;
        $display("[FAIL] native_active expected=%h got=%h",
                 $sampled(exp_d2.active), $sampled(native_active));
    end

    a_csync: assert property (@(posedge clk_col16x) disable iff (rst)
        valid_d[1] |-> csync == exp_d2.csync)
    else
    begin
        err_csync++;
        $display("[FAIL] csync expected=%h got=%h", $sampled(exp_d2.csync), $sampled(csync));
    end

    a_luma: assert property (@(posedge clk_col16x) disable iff (rst)
        valid_d[1] |-> luma == exp_d2.luma)
    else
    begin
        err_luma++;
        $display("[FAIL] luma expected=%h got=%h", $sampled(exp_d2.luma), $sampled(luma));
    end

    a_chroma_zero: assert property (@(posedge clk_col16x) disable iff (rst)
        (valid_d[2] && exp_d3.amp == AMP_NONE) |-> chroma == CHROMA_ZERO)
    else
    begin
        err_chroma++;
        $display("[FAIL] chroma expected=%h got=%h", CHROMA_ZERO, $sampled(chroma));
    end

    // four samples always cover a nonzero point of the carrier
    a_carrier_span: assert property (@(posedge clk_col16x) disable iff (rst)
        (valid_d[2] && exp_d3.amp == AMP_NONE && span_len >= 4) |-> span_seen)
    else
    begin
        err_chroma++;
        $display("chroma stayed at the centre level for a whole carrier run of %0d samples",
                 $sampled(span_len));
    end

    task automatic drive_line(input chip_t c, input raster_y_t y, input int len,
                              input logic rand_col);
        int x;
        x = 0;
        while (x < len)
        begin
            @(posedge clk_col16x);
            chip <= c;
            raster_x <= raster_x_t'(x);
            raster_y <= y;
            // one colour per 8 pixel cell unless the line is random
            if (rand_col)
                pixel_color <= color_idx_t'($urandom);
            else
                pixel_color <= color_idx_t'(x / 8);
            // now and then skip ahead along the line
            if ($urandom % 128 == 0)
                x = x + 2 + int'($urandom % 24);
            else
                x = x + 1;
        end
    endtask

    task automatic run_chip(input chip_t c);
        timing_t   t;
        raster_y_t y;
        logic      rand_col;
        t = select_timing(c);
        for (int i = 0; i < LINES_PER_CHIP; i++)
        begin
            y = t.vblank_start - 9'd3 + raster_y_t'(i);
            rand_col = ($urandom % 4) == 0;
            drive_line(c, y, line_length(c), rand_col);
        end
    endtask

    initial
    begin
        void'($urandom(RAND_SEED));
        rst = 1'b1;
        chip = `CHIP6567R8;
        raster_x = '0;
        raster_y = '0;
        pixel_color = '0;
        repeat (RESET_CYCLES) @(posedge clk_col16x);
        rst <= 1'b0;
        foreach (CHIP_LIST[i])
            run_chip(CHIP_LIST[i]);
        // last inputs reach chroma three edges later
        repeat (5) @(posedge clk_col16x);
        if (bursts_seen == 0)
        begin
            err_chroma++;
            $display("no colour burst was started during the run");
        end
        $display("errors: reset=%0d native_active=%0d csync=%0d luma=%0d chroma=%0d",
                 err_reset, err_active, err_csync, err_luma, err_chroma);
        if (err_reset + err_active + err_csync + err_luma + err_chroma == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the stimulus finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule
